// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_sdio_data_control
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+src
src/sdio_func_pkg.sv
src/sdio_xfer_pkg.sv
src/sdio_func_router.sv
src/sdio_xfer_sequencer.sv
src/sdio_cmd_byte_port.sv
src/sdio_data_control.sv
testbench/tb_sdio_data_control.sv

// ==== src/sdio_cmd_byte_port.sv ====
//////////////////////////////////////////////////
// One-byte reader and writer used while the
// command bus owns the data path.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sdio_data_defs.svh"

module sdio_cmd_byte_port (
  input  logic clk,
  input  logic rst,
  input  logic i_cmd_bus_sel,
  input  logic i_activate,
  input  logic i_write_flg,
  input  logic i_com_rdy,
  input  logic i_rd_stb,
  output logic o_wr_stb,
  output logic o_hst_rdy
);

  sdio_xfer_pkg::byte_port_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= sdio_xfer_pkg::BP_IDLE;
      o_wr_stb  <= 1'b0;
      o_hst_rdy <= 1'b0;
    end else begin
      o_wr_stb <= 1'b0;
      case (state)
        sdio_xfer_pkg::BP_IDLE: begin
          o_hst_rdy <= 1'b0;
          if (i_cmd_bus_sel && i_activate) begin
            o_hst_rdy <= i_write_flg;
            state     <= i_write_flg ? sdio_xfer_pkg::BP_WRITE : sdio_xfer_pkg::BP_READ;
          end
        end
        sdio_xfer_pkg::BP_WRITE: begin
          if (i_com_rdy) begin
            o_wr_stb  <= 1'b1;
            o_hst_rdy <= 1'b0;
            state     <= sdio_xfer_pkg::BP_DONE;
          end
        end
        sdio_xfer_pkg::BP_READ: begin
          // Ready follows the path until the channel hands over its byte
          o_hst_rdy <= i_com_rdy;
          if (i_rd_stb) begin
            o_hst_rdy <= 1'b0;
            state     <= sdio_xfer_pkg::BP_DONE;
          end
        end
        default: begin
          o_hst_rdy <= 1'b0;
        end
      endcase
      if (!i_activate && (state != sdio_xfer_pkg::BP_IDLE)) begin
        o_hst_rdy <= 1'b0;
        state     <= sdio_xfer_pkg::BP_IDLE;
      end
    end
  end

  a_single_wr_stb: assert property (@(posedge clk) disable iff (rst) o_wr_stb |=> !o_wr_stb);

endmodule

// ==== src/sdio_data_control.sv ====
//////////////////////////////////////////////////
// SDIO device data controller top. Connects the
// router, the transfer FSM and the byte port.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sdio_data_defs.svh"

module sdio_data_control #(
  parameter int READ_COOLDOWN = `SDIO_READ_COOLDOWN
) (
  input  logic                                       clk,
  input  logic                                       rst,
  output logic                                       o_data_bus_busy,

  input  logic                                       i_write_flg,
  input  logic                                       i_block_mode_flg,
  input  sdio_xfer_pkg::cnt_t                        i_data_cnt,
  output sdio_xfer_pkg::cnt_t                        o_total_data_cnt,
  input  logic                                       i_inc_addr_flg,
  input  sdio_xfer_pkg::addr_t                       i_cmd_address,
  output sdio_xfer_pkg::addr_t                       o_address,
  input  logic                                       i_activate,
  output logic                                       o_finished,

  input  logic                                       i_cmd_bus_sel,
  input  logic                                       i_mem_sel,
  input  sdio_func_pkg::func_num_t                   i_func_sel,
  input  sdio_func_pkg::byte_t                       i_cmd_wr_data,
  output sdio_func_pkg::byte_t                       o_cmd_rd_data,

  input  logic                                       i_data_phy_wr_stb,
  input  sdio_func_pkg::byte_t                       i_data_phy_wr_data,
  output logic                                       o_data_phy_rd_stb,
  output sdio_func_pkg::byte_t                       o_data_phy_rd_data,
  output logic                                       o_data_phy_com_rdy,
  output logic                                       o_data_phy_activate,
  input  logic                                       i_data_phy_finished,

  output logic [`SDIO_NUM_CH-1:0]                    o_ch_wr_stb,
  output sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]    o_ch_wr_data,
  output logic [`SDIO_NUM_CH-1:0]                    o_ch_hst_rdy,
  output logic [`SDIO_NUM_CH-1:0]                    o_ch_activate,
  input  logic [`SDIO_NUM_CH-1:0]                    i_ch_rd_stb,
  input  sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]    i_ch_rd_data,
  input  logic [`SDIO_NUM_CH-1:0]                    i_ch_com_rdy,
  input  logic [`SDIO_NUM_CH-1:0][`SDIO_BSIZE_W-1:0] i_ch_block_size
);

  logic                     seq_rdy;
  logic                     seq_activate;
  logic                     xfer_stb;
  logic [`SDIO_BSIZE_W-1:0] block_size;
  logic                     bp_wr_stb;
  logic                     bp_hst_rdy;
  logic                     bp_rd_stb;
  logic                     bp_com_rdy;

  sdio_func_router u_router (
    .i_cmd_bus_sel       (i_cmd_bus_sel),
    .i_mem_sel           (i_mem_sel),
    .i_func_sel          (i_func_sel),
    .i_seq_rdy           (seq_rdy),
    .i_seq_activate      (seq_activate),
    .i_activate          (i_activate),
    .i_bp_wr_stb         (bp_wr_stb),
    .i_bp_hst_rdy        (bp_hst_rdy),
    .i_cmd_wr_data       (i_cmd_wr_data),
    .i_data_phy_wr_stb   (i_data_phy_wr_stb),
    .i_data_phy_wr_data  (i_data_phy_wr_data),
    .o_data_phy_rd_stb   (o_data_phy_rd_stb),
    .o_data_phy_rd_data  (o_data_phy_rd_data),
    .o_data_phy_com_rdy  (o_data_phy_com_rdy),
    .o_data_phy_activate (o_data_phy_activate),
    .o_cmd_rd_data       (o_cmd_rd_data),
    .o_bp_rd_stb         (bp_rd_stb),
    .o_com_rdy           (bp_com_rdy),
    .o_xfer_stb          (xfer_stb),
    .o_block_size        (block_size),
    .o_ch_wr_stb         (o_ch_wr_stb),
    .o_ch_wr_data        (o_ch_wr_data),
    .o_ch_hst_rdy        (o_ch_hst_rdy),
    .o_ch_activate       (o_ch_activate),
    .i_ch_rd_stb         (i_ch_rd_stb),
    .i_ch_rd_data        (i_ch_rd_data),
    .i_ch_com_rdy        (i_ch_com_rdy),
    .i_ch_block_size     (i_ch_block_size)
  );

  sdio_xfer_sequencer #(
    .READ_COOLDOWN (READ_COOLDOWN)
  ) u_seq (
    .clk                 (clk),
    .rst                 (rst),
    .i_activate          (i_activate),
    .i_write_flg         (i_write_flg),
    .i_block_mode_flg    (i_block_mode_flg),
    .i_inc_addr_flg      (i_inc_addr_flg),
    .i_data_cnt          (i_data_cnt),
    .i_cmd_address       (i_cmd_address),
    .i_block_size        (block_size),
    .i_xfer_stb          (xfer_stb),
    .i_data_phy_finished (i_data_phy_finished),
    .o_seq_rdy           (seq_rdy),
    .o_seq_activate      (seq_activate),
    .o_total_data_cnt    (o_total_data_cnt),
    .o_address           (o_address),
    .o_finished          (o_finished),
    .o_busy              (o_data_bus_busy)
  );

  sdio_cmd_byte_port u_byte_port (
    .clk           (clk),
    .rst           (rst),
    .i_cmd_bus_sel (i_cmd_bus_sel),
    .i_activate    (i_activate),
    .i_write_flg   (i_write_flg),
    .i_com_rdy     (bp_com_rdy),
    .i_rd_stb      (bp_rd_stb),
    .o_wr_stb      (bp_wr_stb),
    .o_hst_rdy     (bp_hst_rdy)
  );

endmodule

// ==== src/sdio_data_defs.svh ====
//////////////////////////////////////////////////
// Widths and sizes shared by the SDIO data path.
// Include in any file that sizes a port or a type.
//////////////////////////////////////////////////
`ifndef SDIO_DATA_DEFS_SVH
`define SDIO_DATA_DEFS_SVH

`define SDIO_BYTE_W         8
`define SDIO_CNT_W          13
`define SDIO_ADDR_W         18
`define SDIO_BSIZE_W        16

// CIA is channel 0, functions 1 to 7, memory last
`define SDIO_NUM_CH         9
`define SDIO_MEM_CH         8

// Byte mode count of 0 means this many bytes
`define SDIO_BYTE_MODE_MAX  512
`define SDIO_READ_COOLDOWN  400

`endif

// ==== src/sdio_func_pkg.sv ====
//////////////////////////////////////////////////
// Types for the function channels: channel
// number, data byte and host function number.
//////////////////////////////////////////////////
`include "sdio_data_defs.svh"

package sdio_func_pkg;

  // 0 is CIA, 1..7 functions, 8 memory
  typedef logic [3:0] ch_sel_t;

  typedef logic [`SDIO_BYTE_W-1:0] byte_t;

  // Function number as given by the host command
  typedef logic [2:0] func_num_t;

endpackage

// ==== src/sdio_func_router.sv ====
//////////////////////////////////////////////////
// Combinational steering between the command bus
// or data PHY and one of the nine channels.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sdio_data_defs.svh"

module sdio_func_router (
  input  logic                                      i_cmd_bus_sel,
  input  logic                                      i_mem_sel,
  input  sdio_func_pkg::func_num_t                  i_func_sel,

  input  logic                                      i_seq_rdy,
  input  logic                                      i_seq_activate,
  input  logic                                      i_activate,

  input  logic                                      i_bp_wr_stb,
  input  logic                                      i_bp_hst_rdy,
  input  sdio_func_pkg::byte_t                      i_cmd_wr_data,

  input  logic                                      i_data_phy_wr_stb,
  input  sdio_func_pkg::byte_t                      i_data_phy_wr_data,
  output logic                                      o_data_phy_rd_stb,
  output sdio_func_pkg::byte_t                      o_data_phy_rd_data,
  output logic                                      o_data_phy_com_rdy,
  output logic                                      o_data_phy_activate,

  output sdio_func_pkg::byte_t                      o_cmd_rd_data,
  output logic                                      o_bp_rd_stb,
  output logic                                      o_com_rdy,
  output logic                                      o_xfer_stb,
  output logic [`SDIO_BSIZE_W-1:0]                  o_block_size,

  output logic [`SDIO_NUM_CH-1:0]                   o_ch_wr_stb,
  output sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]   o_ch_wr_data,
  output logic [`SDIO_NUM_CH-1:0]                   o_ch_hst_rdy,
  output logic [`SDIO_NUM_CH-1:0]                   o_ch_activate,
  input  logic [`SDIO_NUM_CH-1:0]                   i_ch_rd_stb,
  input  sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]   i_ch_rd_data,
  input  logic [`SDIO_NUM_CH-1:0]                   i_ch_com_rdy,
  input  logic [`SDIO_NUM_CH-1:0][`SDIO_BSIZE_W-1:0] i_ch_block_size
);

  sdio_func_pkg::ch_sel_t ch;
  logic                   wr_stb;
  sdio_func_pkg::byte_t   wr_data;
  logic                   hst_rdy;
  logic                   activate;
  logic                   rd_stb;
  sdio_func_pkg::byte_t   rd_data;
  logic                   com_rdy;

  assign ch = i_mem_sel ? sdio_func_pkg::ch_sel_t'(`SDIO_MEM_CH) : {1'b0, i_func_sel};

  // Write source: byte port on the command bus, otherwise the PHY
  assign wr_stb   = i_cmd_bus_sel ? i_bp_wr_stb   : i_data_phy_wr_stb;
  assign wr_data  = i_cmd_bus_sel ? i_cmd_wr_data : i_data_phy_wr_data;
  assign hst_rdy  = i_cmd_bus_sel ? i_bp_hst_rdy  : i_seq_rdy;
  assign activate = i_cmd_bus_sel ? i_activate    : i_seq_activate;

  // Selected channel back towards the sources
  assign rd_stb       = i_ch_rd_stb[ch];
  assign rd_data      = i_ch_rd_data[ch];
  assign com_rdy      = i_ch_com_rdy[ch] & i_seq_rdy;
  assign o_block_size = i_ch_block_size[ch];
  assign o_xfer_stb   = wr_stb | rd_stb;

  assign o_data_phy_rd_stb   = i_cmd_bus_sel ? 1'b0 : rd_stb;
  assign o_data_phy_rd_data  = i_cmd_bus_sel ? '0   : rd_data;
  assign o_data_phy_com_rdy  = i_cmd_bus_sel ? 1'b0 : com_rdy;
  assign o_data_phy_activate = i_cmd_bus_sel ? 1'b0 : i_seq_activate;

  assign o_bp_rd_stb   = i_cmd_bus_sel ? rd_stb  : 1'b0;
  assign o_cmd_rd_data = i_cmd_bus_sel ? rd_data : '0;
  assign o_com_rdy     = i_cmd_bus_sel ? com_rdy : 1'b0;

  // Unselected channels see all zeros
  always_comb begin
    o_ch_wr_stb       = '0;
    o_ch_wr_data      = '0;
    o_ch_hst_rdy      = '0;
    o_ch_activate     = '0;
    o_ch_wr_stb[ch]   = wr_stb;
    o_ch_wr_data[ch]  = wr_data;
    o_ch_hst_rdy[ch]  = hst_rdy;
    o_ch_activate[ch] = activate;
  end

endmodule

// ==== src/sdio_xfer_pkg.sv ====
//////////////////////////////////////////////////
// Types for a transfer: counts, addresses and the
// states of the sequencer and the byte port.
//////////////////////////////////////////////////
`include "sdio_data_defs.svh"

package sdio_xfer_pkg;

  typedef logic [`SDIO_CNT_W-1:0]  cnt_t;
  typedef logic [`SDIO_ADDR_W-1:0] addr_t;

  typedef enum logic [2:0] {
    XS_IDLE,
    XS_CONFIG,
    XS_ACTIVE,
    XS_WAIT_PHY,
    XS_COOLDOWN,
    XS_FINISHED
  } xfer_state_t;

  typedef enum logic [1:0] {
    BP_IDLE,
    BP_WRITE,
    BP_READ,
    BP_DONE
  } byte_port_state_t;

endpackage

// ==== src/sdio_xfer_sequencer.sv ====
//////////////////////////////////////////////////
// Transfer FSM: sizes each byte run or block,
// counts bytes, steps the address and paces
// blocks with the PHY wait and read cooldown.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sdio_data_defs.svh"

module sdio_xfer_sequencer #(
  parameter int READ_COOLDOWN = `SDIO_READ_COOLDOWN
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_activate,
  input  logic                         i_write_flg,
  input  logic                         i_block_mode_flg,
  input  logic                         i_inc_addr_flg,
  input  sdio_xfer_pkg::cnt_t          i_data_cnt,
  input  sdio_xfer_pkg::addr_t         i_cmd_address,
  input  logic [`SDIO_BSIZE_W-1:0]     i_block_size,
  input  logic                         i_xfer_stb,
  input  logic                         i_data_phy_finished,
  output logic                         o_seq_rdy,
  output logic                         o_seq_activate,
  output sdio_xfer_pkg::cnt_t          o_total_data_cnt,
  output sdio_xfer_pkg::addr_t         o_address,
  output logic                         o_finished,
  output logic                         o_busy
);

  localparam int CD_W = $clog2(READ_COOLDOWN + 1);

  sdio_xfer_pkg::xfer_state_t state;
  sdio_xfer_pkg::cnt_t        byte_cnt;
  sdio_xfer_pkg::cnt_t        block_cnt;
  sdio_xfer_pkg::cnt_t        total_blocks;
  logic                       continuous;
  logic [CD_W-1:0]            cool_cnt;
  logic                       more_blocks;

  assign more_blocks    = continuous || (block_cnt < total_blocks);
  assign o_busy         = (state != sdio_xfer_pkg::XS_IDLE);
  // Ready drops as soon as the run is complete
  assign o_seq_rdy      = (state == sdio_xfer_pkg::XS_ACTIVE) &&
                          (byte_cnt != o_total_data_cnt);
  assign o_seq_activate = (state == sdio_xfer_pkg::XS_ACTIVE) ||
                          (state == sdio_xfer_pkg::XS_WAIT_PHY) ||
                          (state == sdio_xfer_pkg::XS_COOLDOWN);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= sdio_xfer_pkg::XS_IDLE;
      byte_cnt         <= '0;
      block_cnt        <= '0;
      total_blocks     <= '0;
      continuous       <= 1'b0;
      cool_cnt         <= '0;
      o_total_data_cnt <= '0;
      o_address        <= '0;
      o_finished       <= 1'b0;
    end else begin
      o_finished <= (state == sdio_xfer_pkg::XS_FINISHED);
      case (state)
        sdio_xfer_pkg::XS_IDLE: begin
          byte_cnt         <= '0;
          block_cnt        <= '0;
          o_total_data_cnt <= '0;
          o_address        <= i_cmd_address;
          // Block mode with no count runs until activate falls
          continuous       <= i_block_mode_flg && (i_data_cnt == '0);
          total_blocks     <= i_block_mode_flg ? i_data_cnt : '0;
          if (i_activate)
            state <= sdio_xfer_pkg::XS_CONFIG;
        end
        sdio_xfer_pkg::XS_CONFIG: begin
          byte_cnt <= '0;
          if (i_block_mode_flg) begin
            o_total_data_cnt <= i_block_size[`SDIO_CNT_W-1:0];
            if (!continuous)
              block_cnt <= block_cnt + 1'b1;
          end else if (i_data_cnt == '0) begin
            o_total_data_cnt <= sdio_xfer_pkg::cnt_t'(`SDIO_BYTE_MODE_MAX);
          end else begin
            o_total_data_cnt <= i_data_cnt;
          end
          state <= sdio_xfer_pkg::XS_ACTIVE;
        end
        sdio_xfer_pkg::XS_ACTIVE: begin
          if (byte_cnt == o_total_data_cnt) begin
            if (!i_block_mode_flg) begin
              state <= sdio_xfer_pkg::XS_FINISHED;
            end else if (i_write_flg) begin
              state <= sdio_xfer_pkg::XS_WAIT_PHY;
            end else begin
              cool_cnt <= CD_W'(READ_COOLDOWN - 1);
              state    <= sdio_xfer_pkg::XS_COOLDOWN;
            end
          end else if (i_xfer_stb) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (i_inc_addr_flg)
              o_address <= o_address + 1'b1;
          end
        end
        sdio_xfer_pkg::XS_WAIT_PHY: begin
          // PHY signals the end of the block, CRC and busy done
          if (i_data_phy_finished)
            state <= more_blocks ? sdio_xfer_pkg::XS_CONFIG : sdio_xfer_pkg::XS_FINISHED;
        end
        sdio_xfer_pkg::XS_COOLDOWN: begin
          if (cool_cnt == '0)
            state <= more_blocks ? sdio_xfer_pkg::XS_CONFIG : sdio_xfer_pkg::XS_FINISHED;
          else
            cool_cnt <= cool_cnt - 1'b1;
        end
        sdio_xfer_pkg::XS_FINISHED: begin
          // Hold until the host drops activate
        end
        default: begin
          state <= sdio_xfer_pkg::XS_IDLE;
        end
      endcase
      // Cancel or complete from any state
      if (!i_activate) begin
        state      <= sdio_xfer_pkg::XS_IDLE;
        o_finished <= 1'b0;
      end
    end
  end

  a_finished_busy: assert property (@(posedge clk) disable iff (rst) o_finished |-> o_busy);

  a_cnt_bound: assert property (@(posedge clk) disable iff (rst)
    byte_cnt <= o_total_data_cnt);

endmodule

// ==== testbench/tb_sdio_data_control.sv ====
//////////////////////////////////////////////////
// Testbench for the SDIO data controller. Models
// the PHY and the nine channels, checks routing,
// counts, addresses, block pacing and cancel.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sdio_data_defs.svh"

module tb_sdio_data_control;

  localparam int CLK_PERIOD   = 20;
  localparam int COOLDOWN     = 5;
  localparam int CANCEL_AFTER = 21;
  // Bytes over all tests, with margin for the cancelled run
  localparam int TEST_BYTES      = 37 + 512 + 45 + 3 * 12 + 4 * 28 + 2 + CANCEL_AFTER + 16;
  localparam int WATCHDOG_CYCLES = 3 * TEST_BYTES + 40 * 9 + 4 * (COOLDOWN + 10) + 20;

  logic                                       clk;
  logic                                       rst;
  logic                                       o_data_bus_busy;
  logic                                       i_write_flg;
  logic                                       i_block_mode_flg;
  sdio_xfer_pkg::cnt_t                        i_data_cnt;
  sdio_xfer_pkg::cnt_t                        o_total_data_cnt;
  logic                                       i_inc_addr_flg;
  sdio_xfer_pkg::addr_t                       i_cmd_address;
  sdio_xfer_pkg::addr_t                       o_address;
  logic                                       i_activate;
  logic                                       o_finished;
  logic                                       i_cmd_bus_sel;
  logic                                       i_mem_sel;
  sdio_func_pkg::func_num_t                   i_func_sel;
  sdio_func_pkg::byte_t                       i_cmd_wr_data;
  sdio_func_pkg::byte_t                       o_cmd_rd_data;
  logic                                       i_data_phy_wr_stb;
  sdio_func_pkg::byte_t                       i_data_phy_wr_data;
  logic                                       o_data_phy_rd_stb;
  sdio_func_pkg::byte_t                       o_data_phy_rd_data;
  logic                                       o_data_phy_com_rdy;
  logic                                       o_data_phy_activate;
  logic                                       i_data_phy_finished;
  logic [`SDIO_NUM_CH-1:0]                    o_ch_wr_stb;
  sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]    o_ch_wr_data;
  logic [`SDIO_NUM_CH-1:0]                    o_ch_hst_rdy;
  logic [`SDIO_NUM_CH-1:0]                    o_ch_activate;
  logic [`SDIO_NUM_CH-1:0]                    i_ch_rd_stb;
  sdio_func_pkg::byte_t [`SDIO_NUM_CH-1:0]    i_ch_rd_data;
  logic [`SDIO_NUM_CH-1:0]                    i_ch_com_rdy;
  logic [`SDIO_NUM_CH-1:0][`SDIO_BSIZE_W-1:0] i_ch_block_size;

  // Scoreboard state shared by the models and the compare process
  sdio_func_pkg::byte_t   wr_expect[$];
  sdio_func_pkg::byte_t   rd_expect[$];
  sdio_func_pkg::ch_sel_t tgt;
  logic [31:0]            rng;
  logic [15:0]            blk_size;
  int                     wr_seen;
  int                     rd_seen;
  int                     phy_fin_cnt;
  int                     phy_blk_bytes;
  int                     fin_delay;

  sdio_data_control #(
    .READ_COOLDOWN (COOLDOWN)
  ) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected run size, final address and block count of one transfer
  function automatic void xfer_model(input logic blk, input sdio_xfer_pkg::cnt_t cnt,
                                     input logic inc, input sdio_xfer_pkg::addr_t start,
                                     input logic [15:0] bsize,
                                     output sdio_xfer_pkg::cnt_t total,
                                     output sdio_xfer_pkg::addr_t last_addr,
                                     output int blocks);
    int bytes;
    if (blk) begin
      total  = bsize[`SDIO_CNT_W-1:0];
      blocks = int'(cnt);
    end else begin
      total  = (cnt == '0) ? sdio_xfer_pkg::cnt_t'(`SDIO_BYTE_MODE_MAX) : cnt;
      blocks = 1;
    end
    bytes     = int'(total) * blocks;
    last_addr = inc ? start + sdio_xfer_pkg::addr_t'(bytes) : start;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_byte(input string name, input sdio_func_pkg::byte_t got,
                            input sdio_func_pkg::byte_t exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_cnt(input string name, input sdio_xfer_pkg::cnt_t got,
                           input sdio_xfer_pkg::cnt_t exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input sdio_xfer_pkg::addr_t got,
                            input sdio_xfer_pkg::addr_t exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_mask(input string name, input logic [`SDIO_NUM_CH-1:0] got,
                            input logic [`SDIO_NUM_CH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
  endtask

  // PHY model, one write strobe every other cycle and an end of block pulse
  always @(posedge clk) begin
    if (rst || !i_activate || i_cmd_bus_sel) begin
      i_data_phy_wr_stb   <= 1'b0;
      i_data_phy_finished <= 1'b0;
      phy_blk_bytes = 0;
      fin_delay     = 0;
    end else begin
      i_data_phy_wr_stb   <= 1'b0;
      i_data_phy_finished <= 1'b0;
      if (fin_delay != 0) begin
        fin_delay = fin_delay - 1;
        if (fin_delay == 0) begin
          i_data_phy_finished <= 1'b1;
          phy_fin_cnt++;
          phy_blk_bytes = 0;
        end
      end else if (i_write_flg && o_data_phy_com_rdy && !i_data_phy_wr_stb) begin
        rng = xorshift32(rng);
        i_data_phy_wr_stb  <= 1'b1;
        i_data_phy_wr_data <= rng[7:0];
        wr_expect.push_back(rng[7:0]);
        if (i_block_mode_flg) begin
          phy_blk_bytes++;
          // CRC and busy time before the PHY reports the block done
          if (phy_blk_bytes == int'(blk_size))
            fin_delay = 4;
        end
      end
    end
  end

  // Channel models hand over a byte when the host side is ready
  always @(posedge clk) begin
    for (int c = 0; c < `SDIO_NUM_CH; c++) begin
      i_ch_rd_stb[c] <= 1'b0;
      if (!rst && !i_write_flg && o_ch_activate[c] && o_ch_hst_rdy[c] && !i_ch_rd_stb[c]) begin
        rng = xorshift32(rng);
        i_ch_rd_stb[c]  <= 1'b1;
        i_ch_rd_data[c] <= rng[7:0];
        rd_expect.push_back(rng[7:0]);
      end
    end
  end

  always @(posedge clk) begin : compare_outputs
    logic [`SDIO_NUM_CH-1:0] tgt_mask;
    tgt_mask = `SDIO_NUM_CH'(1) << tgt;
    if (!rst) begin
      // Only the selected channel may see ready or activate
      check_mask("o_ch_hst_rdy", o_ch_hst_rdy & ~tgt_mask, '0);
      check_mask("o_ch_activate", o_ch_activate & ~tgt_mask, '0);
      if (o_ch_wr_stb != '0) begin
        check_mask("o_ch_wr_stb", o_ch_wr_stb, tgt_mask);
        if (wr_expect.size() == 0)
          abort_run("channel write strobe with no byte sent by the source");
        check_byte("o_ch_wr_data", o_ch_wr_data[tgt], wr_expect.pop_front());
        wr_seen++;
      end
      if (i_cmd_bus_sel) begin
        // Data PHY stays quiet while the command bus owns the path
        check_bit("o_data_phy_rd_stb", o_data_phy_rd_stb, 1'b0);
        check_byte("o_data_phy_rd_data", o_data_phy_rd_data, '0);
        check_bit("o_data_phy_com_rdy", o_data_phy_com_rdy, 1'b0);
        check_bit("o_data_phy_activate", o_data_phy_activate, 1'b0);
      end else begin
        check_bit("o_data_phy_rd_stb", o_data_phy_rd_stb, i_ch_rd_stb[tgt]);
      end
      if (i_ch_rd_stb[tgt]) begin
        if (rd_expect.size() == 0)
          abort_run("channel read strobe with no byte recorded by the model");
        if (i_cmd_bus_sel)
          check_byte("o_cmd_rd_data", o_cmd_rd_data, rd_expect.pop_front());
        else
          check_byte("o_data_phy_rd_data", o_data_phy_rd_data, rd_expect.pop_front());
        rd_seen++;
      end
    end
  end

  task automatic drive_setup(input logic cmd, input logic wr, input logic blk, input logic inc,
                             input logic mem, input sdio_func_pkg::func_num_t fn,
                             input sdio_xfer_pkg::cnt_t cnt, input sdio_xfer_pkg::addr_t addr);
    tgt      = mem ? sdio_func_pkg::ch_sel_t'(`SDIO_MEM_CH) : sdio_func_pkg::ch_sel_t'(fn);
    blk_size = i_ch_block_size[tgt];
    wr_seen     = 0;
    rd_seen     = 0;
    phy_fin_cnt = 0;
    @(posedge clk);
    i_cmd_bus_sel    <= cmd;
    i_mem_sel        <= mem;
    i_func_sel       <= fn;
    i_write_flg      <= wr;
    i_block_mode_flg <= blk;
    i_inc_addr_flg   <= inc;
    i_data_cnt       <= cnt;
    i_cmd_address    <= addr;
    if (cmd && wr) begin
      rng = xorshift32(rng);
      i_cmd_wr_data <= rng[7:0];
      wr_expect.push_back(rng[7:0]);
    end
    i_activate <= 1'b1;
    @(posedge clk);
  endtask

  task automatic run_xfer(input logic cmd, input logic wr, input logic blk, input logic inc,
                          input logic mem, input sdio_func_pkg::func_num_t fn,
                          input sdio_xfer_pkg::cnt_t cnt, input sdio_xfer_pkg::addr_t addr);
    sdio_xfer_pkg::cnt_t  exp_total;
    sdio_xfer_pkg::addr_t exp_addr;
    int                   exp_blocks;
    int                   moved;
    drive_setup(cmd, wr, blk, inc, mem, fn, cnt, addr);
    xfer_model(blk, cnt, inc, addr, blk_size, exp_total, exp_addr, exp_blocks);
    while (!o_finished)
      @(posedge clk);
    check_cnt("o_total_data_cnt", o_total_data_cnt, exp_total);
    check_addr("o_address", o_address, exp_addr);
    moved = wr ? wr_seen : rd_seen;
    check_cnt("bytes moved", sdio_xfer_pkg::cnt_t'(moved),
              sdio_xfer_pkg::cnt_t'(int'(exp_total) * exp_blocks));
    if (blk && wr)
      check_cnt("PHY finished pulses", sdio_xfer_pkg::cnt_t'(phy_fin_cnt),
                sdio_xfer_pkg::cnt_t'(exp_blocks));
    i_activate <= 1'b0;
    @(posedge clk);
    while (o_data_bus_busy)
      @(posedge clk);
    if (wr_expect.size() != 0 || rd_expect.size() != 0)
      abort_run("bytes were sent but never reached the other side");
  endtask

  // Continuous block write on function 2, dropped part way through
  task automatic cancel_xfer();
    drive_setup(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 3'd2, '0, 18'h2_0000);
    while (wr_seen < CANCEL_AFTER)
      @(posedge clk);
    i_activate <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_bit("o_data_bus_busy", o_data_bus_busy, 1'b0);
    check_mask("o_ch_activate", o_ch_activate, '0);
    check_bit("o_data_phy_activate", o_data_phy_activate, 1'b0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    clk                 = 1'b0;
    rst                 = 1'b1;
    rng                 = 32'h3674875d;
    tgt                 = '0;
    blk_size            = '0;
    i_write_flg         = 1'b0;
    i_block_mode_flg    = 1'b0;
    i_data_cnt          = '0;
    i_inc_addr_flg      = 1'b0;
    i_cmd_address       = '0;
    i_activate          = 1'b0;
    i_cmd_bus_sel       = 1'b0;
    i_mem_sel           = 1'b0;
    i_func_sel          = '0;
    i_cmd_wr_data       = '0;
    i_data_phy_wr_stb   = 1'b0;
    i_data_phy_wr_data  = '0;
    i_data_phy_finished = 1'b0;
    i_ch_rd_stb         = '0;
    i_ch_rd_data        = '0;
    i_ch_com_rdy        = '1;
    // Each channel gets its own block size
    for (int c = 0; c < `SDIO_NUM_CH; c++)
      i_ch_block_size[c] = 16'(8 + 4 * c);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    run_xfer(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 3'd3, 13'd37, 18'h1_0F00);
    run_xfer(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 3'd3, 13'd0, 18'h3_FF80);
    run_xfer(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd0, 13'd45, 18'h0_2345);
    run_xfer(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 3'd1, 13'd3, 18'h0_0100);
    run_xfer(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 3'd5, 13'd4, 18'h0_0400);
    // Single bytes over the command bus to and from the CIA
    run_xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 13'd1, 18'h0_1008);
    run_xfer(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 13'd1, 18'h0_0007);
    cancel_xfer();
    repeat (4) @(posedge clk);

    $display("Simulation passed");
    $finish;
  end

endmodule
